/* hdl/carry_pkg.sv */
// Carry stage shared definitions

package carry_pkg;

  // ----------------------------------------------------------------------
  // Widths and constants
  // ----------------------------------------------------------------------

  // One bitstream byte
  localparam int byte_width = 8;

  // Encoder lanes delivered per cycle
  localparam int lane_count = 3;

  // Byte value that may still absorb a later carry
  localparam logic [byte_width-1:0] byte_all_ones = '1;

  // ----------------------------------------------------------------------
  // Types
  // ----------------------------------------------------------------------

  typedef logic [byte_width-1:0] byte_t;

  // Bit 8 is the carry, bits 7..0 the byte
  typedef logic [byte_width:0] carry_byte_t;

  // Count of deferred all-ones bytes
  typedef logic [7:0] run_t;

endpackage

/* hdl/lane_compactor.sv */
// Encoder lane compactor

`timescale 1ns/1ps

module lane_compactor (
  input  logic                   lane_valid_1,
  input  logic                   lane_valid_2,
  input  logic                   lane_valid_3,
  input  carry_pkg::carry_byte_t lane_byte_1,
  input  carry_pkg::carry_byte_t lane_byte_2,
  input  carry_pkg::carry_byte_t lane_byte_3,
  output logic                   pack_valid_1,
  output logic                   pack_valid_2,
  output logic                   pack_valid_3,
  output carry_pkg::carry_byte_t pack_byte_1,
  output carry_pkg::carry_byte_t pack_byte_2,
  output carry_pkg::carry_byte_t pack_byte_3
);

  logic [carry_pkg::lane_count-1:0] in_valid;
  logic [carry_pkg::lane_count-1:0] out_valid;
  carry_pkg::carry_byte_t           in_byte  [carry_pkg::lane_count];
  carry_pkg::carry_byte_t           out_byte [carry_pkg::lane_count];

  assign in_valid   = {lane_valid_3, lane_valid_2, lane_valid_1};
  assign in_byte[0] = lane_byte_1;
  assign in_byte[1] = lane_byte_2;
  assign in_byte[2] = lane_byte_3;

  // Each valid lane takes the next free slot, keeping input order
  always_comb begin
    int slot;
    slot      = 0;
    out_valid = '0;
    for (int i = 0; i < carry_pkg::lane_count; i++) begin
      out_byte[i] = '0;
    end
    for (int i = 0; i < carry_pkg::lane_count; i++) begin
      if (in_valid[i]) begin
        out_valid[slot] = 1'b1;
        out_byte[slot]  = in_byte[i];
        slot            = slot + 1;
      end
    end
  end

  assign pack_valid_1 = out_valid[0];
  assign pack_valid_2 = out_valid[1];
  assign pack_valid_3 = out_valid[2];
  assign pack_byte_1  = out_byte[0];
  assign pack_byte_2  = out_byte[1];
  assign pack_byte_3  = out_byte[2];

endmodule

/* hdl/carry_cell.sv */
// Single lane carry propagation

`timescale 1ns/1ps

module carry_cell (
  input  logic                   lane_valid,
  input  carry_pkg::carry_byte_t lane_byte,
  input  logic                   have_prev_in,
  input  carry_pkg::byte_t       prev_in,
  input  carry_pkg::run_t        run_in,
  output logic                   have_prev_out,
  output carry_pkg::byte_t       prev_out,
  output carry_pkg::run_t        run_out,
  output logic                   rel_valid,
  output carry_pkg::byte_t       rel_byte,
  output carry_pkg::run_t        rel_run,
  output logic                   rel_fill
);

  logic             carry;
  carry_pkg::byte_t low_byte;

  assign carry    = lane_byte[carry_pkg::byte_width];
  assign low_byte = lane_byte[carry_pkg::byte_width-1:0];

  // Release record, only meaningful when rel_valid is set
  // A carry turns the pending all-ones run into zeros
  assign rel_byte = prev_in + carry_pkg::byte_t'(carry);
  assign rel_run  = run_in;
  assign rel_fill = carry;

  // ----------------------------------------------------------------------
  // Hold, defer or release
  // ----------------------------------------------------------------------
  always_comb begin
    have_prev_out = have_prev_in;
    prev_out      = prev_in;
    run_out       = run_in;
    rel_valid     = 1'b0;
    if (lane_valid) begin
      if (!have_prev_in) begin
        // First byte of a stream, nothing before it to carry into
        have_prev_out = 1'b1;
        prev_out      = low_byte;
      end else if (!carry && low_byte == carry_pkg::byte_all_ones) begin
        // Still open to a later carry
        run_out = run_in + 1'b1;
      end else begin
        rel_valid = 1'b1;
        prev_out  = low_byte;
        run_out   = '0;
      end
    end
  end

endmodule

/* hdl/carry_state.sv */
// Held byte state and flush release

`timescale 1ns/1ps

module carry_state (
  input  logic             s4_clk,
  input  logic             arst_n,
  input  logic             flush,
  input  logic             have_prev_next,
  input  carry_pkg::byte_t prev_next,
  input  carry_pkg::run_t  run_next,
  output logic             have_prev,
  output carry_pkg::byte_t prev_byte,
  output carry_pkg::run_t  run,
  output logic             last_valid,
  output carry_pkg::byte_t last_byte,
  output carry_pkg::run_t  last_run
);

  // ----------------------------------------------------------------------
  // Control state
  // ----------------------------------------------------------------------
  always_ff @(posedge s4_clk or negedge arst_n) begin
    if (!arst_n) begin
      have_prev  <= 1'b0;
      run        <= '0;
      last_valid <= 1'b0;
    end else begin
      // Only a stream that held a byte has something to close
      last_valid <= flush & have_prev;
      if (flush) begin
        have_prev <= 1'b0;
        run       <= '0;
      end else begin
        have_prev <= have_prev_next;
        run       <= run_next;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Held byte and last record
  // ----------------------------------------------------------------------
  always_ff @(posedge s4_clk) begin
    // Ignored while have_prev is low
    prev_byte <= prev_next;
    if (flush && have_prev) begin
      last_byte <= prev_byte;
      last_run  <= run;
    end
  end

endmodule

/* hdl/release_register.sv */
// Release record output register

`timescale 1ns/1ps

module release_register (
  input  logic             s4_clk,
  input  logic             arst_n,
  input  logic             rel_valid_in_1,
  input  carry_pkg::byte_t rel_byte_in_1,
  input  carry_pkg::run_t  rel_run_in_1,
  input  logic             rel_fill_in_1,
  input  logic             rel_valid_in_2,
  input  carry_pkg::byte_t rel_byte_in_2,
  input  carry_pkg::run_t  rel_run_in_2,
  input  logic             rel_fill_in_2,
  input  logic             rel_valid_in_3,
  input  carry_pkg::byte_t rel_byte_in_3,
  input  carry_pkg::run_t  rel_run_in_3,
  input  logic             rel_fill_in_3,
  output logic             rel_valid_1,
  output carry_pkg::byte_t rel_byte_1,
  output carry_pkg::run_t  rel_run_1,
  output logic             rel_fill_1,
  output logic             rel_valid_2,
  output carry_pkg::byte_t rel_byte_2,
  output carry_pkg::run_t  rel_run_2,
  output logic             rel_fill_2,
  output logic             rel_valid_3,
  output carry_pkg::byte_t rel_byte_3,
  output carry_pkg::run_t  rel_run_3,
  output logic             rel_fill_3
);

  always_ff @(posedge s4_clk or negedge arst_n) begin
    if (!arst_n) begin
      rel_valid_1 <= 1'b0;
      rel_valid_2 <= 1'b0;
      rel_valid_3 <= 1'b0;
    end else begin
      rel_valid_1 <= rel_valid_in_1;
      rel_valid_2 <= rel_valid_in_2;
      rel_valid_3 <= rel_valid_in_3;
    end
  end

  // Data holds its last value while its lane is idle
  always_ff @(posedge s4_clk) begin
    if (rel_valid_in_1) begin
      rel_byte_1 <= rel_byte_in_1;
      rel_run_1  <= rel_run_in_1;
      rel_fill_1 <= rel_fill_in_1;
    end
    if (rel_valid_in_2) begin
      rel_byte_2 <= rel_byte_in_2;
      rel_run_2  <= rel_run_in_2;
      rel_fill_2 <= rel_fill_in_2;
    end
    if (rel_valid_in_3) begin
      rel_byte_3 <= rel_byte_in_3;
      rel_run_3  <= rel_run_in_3;
      rel_fill_3 <= rel_fill_in_3;
    end
  end

endmodule

/* hdl/stage_4_carry.sv */
// Carry propagation stage top

`timescale 1ns/1ps

module stage_4_carry (
  input  logic                   s4_clk,
  input  logic                   arst_n,
  input  logic                   lane_valid_1,
  input  logic                   lane_valid_2,
  input  logic                   lane_valid_3,
  input  carry_pkg::carry_byte_t lane_byte_1,
  input  carry_pkg::carry_byte_t lane_byte_2,
  input  carry_pkg::carry_byte_t lane_byte_3,
  input  logic                   flush,
  output logic                   rel_valid_1,
  output carry_pkg::byte_t       rel_byte_1,
  output carry_pkg::run_t        rel_run_1,
  output logic                   rel_fill_1,
  output logic                   rel_valid_2,
  output carry_pkg::byte_t       rel_byte_2,
  output carry_pkg::run_t        rel_run_2,
  output logic                   rel_fill_2,
  output logic                   rel_valid_3,
  output carry_pkg::byte_t       rel_byte_3,
  output carry_pkg::run_t        rel_run_3,
  output logic                   rel_fill_3,
  output logic                   last_valid,
  output carry_pkg::byte_t       last_byte,
  output carry_pkg::run_t        last_run
);

  // Packed lanes
  logic                   pack_valid_1, pack_valid_2, pack_valid_3;
  carry_pkg::carry_byte_t pack_byte_1, pack_byte_2, pack_byte_3;

  // State chain, registered state then after each cell
  logic             have_prev, have_prev_1, have_prev_2, have_prev_3;
  carry_pkg::byte_t prev_byte, prev_1, prev_2, prev_3;
  carry_pkg::run_t  run, run_1, run_2, run_3;

  // Combinational release records
  logic             cell_valid_1, cell_valid_2, cell_valid_3;
  carry_pkg::byte_t cell_byte_1, cell_byte_2, cell_byte_3;
  carry_pkg::run_t  cell_run_1, cell_run_2, cell_run_3;
  logic             cell_fill_1, cell_fill_2, cell_fill_3;

  lane_compactor u_compactor (
    .lane_valid_1 (lane_valid_1),
    .lane_valid_2 (lane_valid_2),
    .lane_valid_3 (lane_valid_3),
    .lane_byte_1  (lane_byte_1),
    .lane_byte_2  (lane_byte_2),
    .lane_byte_3  (lane_byte_3),
    .pack_valid_1 (pack_valid_1),
    .pack_valid_2 (pack_valid_2),
    .pack_valid_3 (pack_valid_3),
    .pack_byte_1  (pack_byte_1),
    .pack_byte_2  (pack_byte_2),
    .pack_byte_3  (pack_byte_3)
  );

  // ----------------------------------------------------------------------
  // Three cells chained through the held-byte state
  // ----------------------------------------------------------------------
  carry_cell u_cell_1 (
    .lane_valid    (pack_valid_1),
    .lane_byte     (pack_byte_1),
    .have_prev_in  (have_prev),
    .prev_in       (prev_byte),
    .run_in        (run),
    .have_prev_out (have_prev_1),
    .prev_out      (prev_1),
    .run_out       (run_1),
    .rel_valid     (cell_valid_1),
    .rel_byte      (cell_byte_1),
    .rel_run       (cell_run_1),
    .rel_fill      (cell_fill_1)
  );

  carry_cell u_cell_2 (
    .lane_valid    (pack_valid_2),
    .lane_byte     (pack_byte_2),
    .have_prev_in  (have_prev_1),
    .prev_in       (prev_1),
    .run_in        (run_1),
    .have_prev_out (have_prev_2),
    .prev_out      (prev_2),
    .run_out       (run_2),
    .rel_valid     (cell_valid_2),
    .rel_byte      (cell_byte_2),
    .rel_run       (cell_run_2),
    .rel_fill      (cell_fill_2)
  );

  carry_cell u_cell_3 (
    .lane_valid    (pack_valid_3),
    .lane_byte     (pack_byte_3),
    .have_prev_in  (have_prev_2),
    .prev_in       (prev_2),
    .run_in        (run_2),
    .have_prev_out (have_prev_3),
    .prev_out      (prev_3),
    .run_out       (run_3),
    .rel_valid     (cell_valid_3),
    .rel_byte      (cell_byte_3),
    .rel_run       (cell_run_3),
    .rel_fill      (cell_fill_3)
  );

  carry_state u_state (
    .s4_clk         (s4_clk),
    .arst_n         (arst_n),
    .flush          (flush),
    .have_prev_next (have_prev_3),
    .prev_next      (prev_3),
    .run_next       (run_3),
    .have_prev      (have_prev),
    .prev_byte      (prev_byte),
    .run            (run),
    .last_valid     (last_valid),
    .last_byte      (last_byte),
    .last_run       (last_run)
  );

  release_register u_release (
    .s4_clk         (s4_clk),
    .arst_n         (arst_n),
    .rel_valid_in_1 (cell_valid_1),
    .rel_byte_in_1  (cell_byte_1),
    .rel_run_in_1   (cell_run_1),
    .rel_fill_in_1  (cell_fill_1),
    .rel_valid_in_2 (cell_valid_2),
    .rel_byte_in_2  (cell_byte_2),
    .rel_run_in_2   (cell_run_2),
    .rel_fill_in_2  (cell_fill_2),
    .rel_valid_in_3 (cell_valid_3),
    .rel_byte_in_3  (cell_byte_3),
    .rel_run_in_3   (cell_run_3),
    .rel_fill_in_3  (cell_fill_3),
    .rel_valid_1    (rel_valid_1),
    .rel_byte_1     (rel_byte_1),
    .rel_run_1      (rel_run_1),
    .rel_fill_1     (rel_fill_1),
    .rel_valid_2    (rel_valid_2),
    .rel_byte_2     (rel_byte_2),
    .rel_run_2      (rel_run_2),
    .rel_fill_2     (rel_fill_2),
    .rel_valid_3    (rel_valid_3),
    .rel_byte_3     (rel_byte_3),
    .rel_run_3      (rel_run_3),
    .rel_fill_3     (rel_fill_3)
  );

endmodule

/* test/stage_4_carry_assert.sv */
// Carry stage protocol assertions

`timescale 1ns/1ps

module stage_4_carry_assert (
  input logic s4_clk,
  input logic arst_n,
  input logic lane_valid_1,
  input logic lane_valid_2,
  input logic lane_valid_3,
  input logic flush,
  input logic rel_valid_1,
  input logic rel_valid_2,
  input logic rel_valid_3,
  input logic last_valid
);

  logic [1:0] lane_total;

  assign lane_total = 2'(lane_valid_1) + 2'(lane_valid_2) + 2'(lane_valid_3);

  // Flush closes a stream and carries no byte of its own
  flush_alone: assert property (@(posedge s4_clk) disable iff (!arst_n)
    flush |-> lane_total == 2'd0)
    else $error("flush came together with a valid lane");

  // Records only reach output lanes that held a packed byte
  pack_1: assert property (@(posedge s4_clk) disable iff (!arst_n)
    lane_total == 2'd0 |=> !rel_valid_1)
    else $error("rel_valid_1 without any input lane");

  pack_2: assert property (@(posedge s4_clk) disable iff (!arst_n)
    lane_total < 2'd2 |=> !rel_valid_2)
    else $error("rel_valid_2 with fewer than two input lanes");

  pack_3: assert property (@(posedge s4_clk) disable iff (!arst_n)
    lane_total < 2'd3 |=> !rel_valid_3)
    else $error("rel_valid_3 with fewer than three input lanes");

  reset_quiet: assert property (@(posedge s4_clk)
    !arst_n |-> !(rel_valid_1 || rel_valid_2 || rel_valid_3 || last_valid))
    else $error("valid output raised during reset");

endmodule

bind stage_4_carry stage_4_carry_assert u_assert (.*);

/* test/stage_4_carry_tb.sv */
// Carry stage testbench

`timescale 1ns/1ps

module stage_4_carry_tb;

  localparam int random_cycles = 400;
  // Reset, directed sequences, random traffic and drain
  localparam int total_cycles  = 3 + 40 + random_cycles + 4;

  typedef struct packed {
    logic [2:0]             valid;
    carry_pkg::byte_t [2:0] bytes;
    carry_pkg::run_t [2:0]  runs;
    logic [2:0]             fill;
    logic                   last_valid;
    carry_pkg::byte_t       last_byte;
    carry_pkg::run_t        last_run;
  } expect_t;

  logic                   s4_clk;
  logic                   arst_n;
  logic                   lane_valid_1, lane_valid_2, lane_valid_3;
  carry_pkg::carry_byte_t lane_byte_1, lane_byte_2, lane_byte_3;
  logic                   flush;
  logic                   rel_valid_1, rel_valid_2, rel_valid_3;
  carry_pkg::byte_t       rel_byte_1, rel_byte_2, rel_byte_3;
  carry_pkg::run_t        rel_run_1, rel_run_2, rel_run_3;
  logic                   rel_fill_1, rel_fill_2, rel_fill_3;
  logic                   last_valid;
  carry_pkg::byte_t       last_byte;
  carry_pkg::run_t        last_run;

  // Model of the held byte state
  logic             model_have;
  carry_pkg::byte_t model_prev;
  carry_pkg::run_t  model_run;

  logic [31:0] lfsr;
  expect_t     exp_q[$];
  int          driven;
  int          checked;

  stage_4_carry dut (.*);

  initial begin
    s4_clk = 1'b0;
    forever #2 s4_clk = ~s4_clk;
  end

  // ----------------------------------------------------------------------
  // Reference model and random source
  // ----------------------------------------------------------------------

  // Galois LFSR, one step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return bits;
  endfunction

  // Occupied lanes in input order, each owning the next output slot
  function automatic expect_t predict(input logic [2:0] v,
                                      input carry_pkg::carry_byte_t [2:0] b,
                                      input logic fl);
    expect_t          e;
    int               slot;
    logic             c;
    carry_pkg::byte_t lo;
    e    = '0;
    slot = 0;
    for (int i = 0; i < 3; i++) begin
      if (v[i]) begin
        c  = b[i][8];
        lo = b[i][7:0];
        if (!model_have) begin
          model_have = 1'b1;
          model_prev = lo;
        end else if (!c && lo == 8'hff) begin
          model_run = model_run + 8'd1;
        end else begin
          e.valid[slot] = 1'b1;
          e.bytes[slot] = model_prev + {7'd0, c};
          e.runs[slot]  = model_run;
          e.fill[slot]  = c;
          model_prev    = lo;
          model_run     = '0;
        end
        slot++;
      end
    end
    if (fl) begin
      e.last_valid = model_have;
      e.last_byte  = model_prev;
      e.last_run   = model_run;
      model_have   = 1'b0;
      model_run    = '0;
    end
    return e;
  endfunction

  // ----------------------------------------------------------------------
  // Stimulus and checking tasks
  // ----------------------------------------------------------------------
  task automatic stop_on_error();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [7:0] got,
                             input logic [7:0] want);
    assert (got === want) else begin
      $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, want);
      stop_on_error();
    end
  endtask

  task automatic check_outputs(input expect_t e);
    logic [2:0]             got_valid;
    carry_pkg::byte_t [2:0] got_byte;
    carry_pkg::run_t [2:0]  got_run;
    logic [2:0]             got_fill;
    got_valid = {rel_valid_3, rel_valid_2, rel_valid_1};
    got_byte  = {rel_byte_3, rel_byte_2, rel_byte_1};
    got_run   = {rel_run_3, rel_run_2, rel_run_1};
    got_fill  = {rel_fill_3, rel_fill_2, rel_fill_1};
    for (int k = 0; k < 3; k++) begin
      check_value($sformatf("rel_valid_%0d", k + 1), got_valid[k], e.valid[k]);
      if (e.valid[k]) begin
        check_value($sformatf("rel_byte_%0d", k + 1), got_byte[k], e.bytes[k]);
        check_value($sformatf("rel_run_%0d", k + 1), got_run[k], e.runs[k]);
        check_value($sformatf("rel_fill_%0d", k + 1), got_fill[k], e.fill[k]);
      end
    end
    check_value("last_valid", last_valid, e.last_valid);
    if (e.last_valid) begin
      check_value("last_byte", last_byte, e.last_byte);
      check_value("last_run", last_run, e.last_run);
    end
  endtask

  task automatic drive(input logic [2:0] v, input carry_pkg::carry_byte_t [2:0] b,
                       input logic fl);
    @(negedge s4_clk);
    {lane_valid_3, lane_valid_2, lane_valid_1} = v;
    lane_byte_1 = b[0];
    lane_byte_2 = b[1];
    lane_byte_3 = b[2];
    flush       = fl;
    exp_q.push_back(predict(v, b, fl));
    driven++;
  endtask

  task automatic send_one(input carry_pkg::carry_byte_t b);
    drive(3'b001, {9'h000, 9'h000, b}, 1'b0);
  endtask

  task automatic random_cycle();
    carry_pkg::carry_byte_t [2:0] b;
    logic                         c;
    for (int i = 0; i < 3; i++) begin
      c    = (take_bits(2) == 0);
      b[i] = {c, carry_pkg::byte_t'(take_bits(8))};
      // Half the bytes are all ones, runs kept short of saturation
      if (take_bits(1) && model_run < 240) begin
        b[i][7:0] = carry_pkg::byte_all_ones;
      end
    end
    if (take_bits(3) == 0) begin
      drive(3'b000, b, 1'b1);
    end else begin
      drive(take_bits(3), b, 1'b0);
    end
  endtask

  // Outputs for one cycle's inputs are compared a cycle later
  initial begin : compare
    expect_t e;
    forever begin
      @(posedge s4_clk);
      #1;
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        check_outputs(e);
        checked++;
      end
    end
  end

  initial begin : watchdog
    #(total_cycles * 4 + 100);
    $display("Watchdog expired before the test sequence finished");
    stop_on_error();
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin : stimulus
    lfsr         = 32'ha3ca_9d56;
    model_have   = 1'b0;
    model_prev   = '0;
    model_run    = '0;
    driven       = 0;
    checked      = 0;
    arst_n       = 1'b0;
    flush        = 1'b0;
    lane_valid_1 = 1'b0;
    lane_valid_2 = 1'b0;
    lane_valid_3 = 1'b0;
    lane_byte_1  = '0;
    lane_byte_2  = '0;
    lane_byte_3  = '0;
    repeat (3) @(posedge s4_clk);
    @(negedge s4_clk);
    arst_n = 1'b1;
    check_outputs('0);

    // Plain single lane stream
    send_one(9'h012);
    send_one(9'h034);
    send_one(9'h056);
    // Carries, including a held 0xff wrapping to zero
    send_one(9'h178);
    send_one(9'h1ff);
    send_one(9'h101);
    // Pending runs closed without and with a carry
    repeat (5) send_one(9'h0ff);
    send_one(9'h022);
    repeat (3) send_one(9'h0ff);
    send_one(9'h133);
    // Gapped lane patterns
    drive(3'b100, {9'h044, 9'h0aa, 9'h0bb}, 1'b0);
    drive(3'b101, {9'h155, 9'h0cc, 9'h066}, 1'b0);
    drive(3'b111, {9'h0ab, 9'h0ff, 9'h1ff}, 1'b0);
    // Flush, then a fresh stream whose first carry is dropped
    drive(3'b000, '0, 1'b0);
    drive(3'b000, '0, 1'b1);
    drive(3'b000, '0, 1'b0);
    send_one(9'h1ff);
    send_one(9'h101);
    repeat (2) send_one(9'h0ff);
    drive(3'b000, '0, 1'b1);
    drive(3'b000, '0, 1'b1);

    repeat (random_cycles) random_cycle();
    drive(3'b000, '0, 1'b0);
    drive(3'b000, '0, 1'b0);
    @(posedge s4_clk);
    #2;
    if (checked != driven) begin
      $display("Only %0d of %0d predictions were compared", checked, driven);
      stop_on_error();
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

/* tb.f */
hdl/carry_pkg.sv
hdl/lane_compactor.sv
hdl/carry_cell.sv
hdl/carry_state.sv
hdl/release_register.sv
hdl/stage_4_carry.sv
test/stage_4_carry_assert.sv
test/stage_4_carry_tb.sv
